//--- source/amo_macros.svh
// AMO engine shared parameters
// Data and address widths, APB register map, memory window and read latency
`ifndef AMO_MACROS_SVH
`define AMO_MACROS_SVH

// Word width and memory word-address width, 16 words in total
`define AMO_DATA_W      32
`define AMO_ADDR_W      4

// Cycles from read strobe to valid read data, legal range 1 to 8
`define AMO_MEM_RD_LAT  2
// Width of the latency timer, wide enough for AMO_MEM_RD_LAT - 1
`define AMO_TIMER_W     3

// APB address width and register byte offsets
`define AMO_PADDR_W     12
`define AMO_REG_ADDR    'h00
`define AMO_REG_OPERAND 'h04
`define AMO_REG_CMD     'h08
`define AMO_REG_RESULT  'h0C
`define AMO_REG_STATUS  'h10

// Direct memory window, one APB word per memory word
`define AMO_WIN_BASE    'h100
`define AMO_WIN_WORDS   16

`endif

//--- source/amo_pkg.sv
// AMO engine types
// Operation codes follow the RISC-V AMO funct5 field
`default_nettype none

package amo_pkg;

    // Bits 4 and 3 both set select an unsigned compare
    typedef enum logic [4:0] {
        AMO_ADD  = 5'b00000,
        AMO_SWAP = 5'b00001,
        AMO_XOR  = 5'b00100,
        AMO_OR   = 5'b01000,
        AMO_AND  = 5'b01100,
        AMO_MIN  = 5'b10000,
        AMO_MAX  = 5'b10100,
        AMO_MINU = 5'b11000,
        AMO_MAXU = 5'b11100
    } amo_op_t;

    // Read-modify-write sequence of the controller
    // WRITE is skipped for read-only window accesses
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        READ   = 3'd1,
        WAIT   = 3'd2,
        MODIFY = 3'd3,
        WRITE  = 3'd4,
        DONE   = 3'd5
    } amo_state_t;

endpackage

`default_nettype wire

//--- source/amo_alu.sv
// AMO ALU
// Combines the loaded word with the operand for every RISC-V AMO operation
`timescale 1ns/1ps
`default_nettype none

`include "amo_macros.svh"

module amo_alu (
    input  amo_pkg::amo_op_t         op,
    input  logic [`AMO_DATA_W-1:0]   rs1_load,
    input  logic [`AMO_DATA_W-1:0]   rs2,
    output logic [`AMO_DATA_W-1:0]   result
);

    logic                    sign_ext;
    logic signed [`AMO_DATA_W:0] rs1_ext;
    logic signed [`AMO_DATA_W:0] rs2_ext;
    logic                    rs1_lt_rs2;

    // MINU and MAXU have both bit 4 and bit 3 set, every other op extends the sign
    assign sign_ext = ~(op[4] & op[3]);

    // One extra bit lets a single signed compare serve both kinds of min and max
    assign rs1_ext = {sign_ext & rs1_load[`AMO_DATA_W-1], rs1_load};
    assign rs2_ext = {sign_ext & rs2[`AMO_DATA_W-1], rs2};

    assign rs1_lt_rs2 = rs1_ext < rs2_ext;

    always_comb begin
        unique case (op)
            amo_pkg::AMO_SWAP: result = rs2;
            amo_pkg::AMO_ADD:  result = rs1_load + rs2;
            amo_pkg::AMO_XOR:  result = rs1_load ^ rs2;
            amo_pkg::AMO_AND:  result = rs1_load & rs2;
            amo_pkg::AMO_OR:   result = rs1_load | rs2;
            amo_pkg::AMO_MIN,
            amo_pkg::AMO_MINU: result = rs1_lt_rs2 ? rs1_load : rs2;
            amo_pkg::AMO_MAX,
            amo_pkg::AMO_MAXU: result = rs1_lt_rs2 ? rs2 : rs1_load;
            // Unused codes leave memory as it was
            default:           result = rs1_load;
        endcase
    end

    // The register block filters illegal codes, so a known op is always a real AMO
    always_comb begin
        if (!$isunknown(op)) begin
            op_legal_chk: assert #0 (op inside {amo_pkg::AMO_SWAP, amo_pkg::AMO_ADD,
                                                 amo_pkg::AMO_XOR, amo_pkg::AMO_AND,
                                                 amo_pkg::AMO_OR, amo_pkg::AMO_MIN,
                                                 amo_pkg::AMO_MAX, amo_pkg::AMO_MINU,
                                                 amo_pkg::AMO_MAXU})
                else $error("ALU sees illegal op %05b", op);
        end
    end

endmodule

`default_nettype wire

//--- source/amo_wait_timer.sv
// Memory latency timer
// Counts the read latency down after a load and flags the last wait cycle
`timescale 1ns/1ps
`default_nettype none

`include "amo_macros.svh"

module amo_wait_timer (
    input  logic clk,
    input  logic arst_n,
    input  logic timer_load,
    output logic expired
);

    localparam logic [`AMO_TIMER_W-1:0] load_val = `AMO_TIMER_W'(`AMO_MEM_RD_LAT - 1);

    logic [`AMO_TIMER_W-1:0] count;
    logic                    running;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count   <= '0;
            running <= 1'b0;
        end else if (timer_load) begin
            count   <= load_val;
            running <= 1'b1;
        end else if (running) begin
            // Stop once the zero cycle has been seen
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign expired = running && (count == '0);

    // Expiry lands exactly one latency after the load that started it
    expire_load_chk: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(expired) |-> $past(timer_load, `AMO_MEM_RD_LAT));

endmodule

`default_nettype wire

//--- source/amo_scratch_mem.sv
// Scratch memory
// Single-port word memory with a fixed read latency and held read data
`timescale 1ns/1ps
`default_nettype none

`include "amo_macros.svh"

module amo_scratch_mem (
    input  logic                     clk,
    input  logic                     mem_rd,
    input  logic                     mem_we,
    input  logic [`AMO_ADDR_W-1:0]   mem_addr,
    input  logic [`AMO_DATA_W-1:0]   mem_wdata,
    output logic [`AMO_DATA_W-1:0]   mem_rdata
);

    logic [`AMO_DATA_W-1:0]   mem [2**`AMO_ADDR_W];
    logic [`AMO_DATA_W-1:0]   rd_data [`AMO_MEM_RD_LAT];
    logic [`AMO_MEM_RD_LAT-1:0] rd_vld;

    // Contents start at zero, there is no reset port
    initial begin
        for (int i = 0; i < 2**`AMO_ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // Each stage only moves when a read is travelling, so the last one holds
    always_ff @(posedge clk) begin
        rd_vld[0] <= mem_rd;
        if (mem_rd) begin
            rd_data[0] <= mem[mem_addr];
        end
        for (int i = 1; i < `AMO_MEM_RD_LAT; i++) begin
            rd_vld[i] <= rd_vld[i-1];
            if (rd_vld[i-1]) begin
                rd_data[i] <= rd_data[i-1];
            end
        end
    end

    assign mem_rdata = rd_data[`AMO_MEM_RD_LAT-1];

    // The controller writes back only after the read has fully drained
    no_wr_in_flight_chk: assert property (@(posedge clk)
        mem_we |-> !(|rd_vld));

endmodule

`default_nettype wire

//--- source/amo_ctrl_fsm.sv
// AMO controller
// Sequences the memory read, the latency wait, the ALU step and the write-back
`timescale 1ns/1ps
`default_nettype none

`include "amo_macros.svh"

module amo_ctrl_fsm (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  logic                     cmd_rd_only,
    output logic                     done,
    output logic                     timer_load,
    input  logic                     expired,
    output logic                     mem_rd,
    output logic                     mem_we,
    input  logic [`AMO_DATA_W-1:0]   mem_rdata,
    input  logic [`AMO_DATA_W-1:0]   alu_result,
    output logic [`AMO_DATA_W-1:0]   old_data,
    output logic [`AMO_DATA_W-1:0]   new_data
);

    amo_pkg::amo_state_t state;
    amo_pkg::amo_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        unique case (state)
            amo_pkg::IDLE:   if (start) state_nxt = amo_pkg::READ;
            amo_pkg::READ:   state_nxt = amo_pkg::WAIT;
            amo_pkg::WAIT:   if (expired) state_nxt = amo_pkg::MODIFY;
            // Window reads finish without touching memory again
            amo_pkg::MODIFY: state_nxt = cmd_rd_only ? amo_pkg::DONE : amo_pkg::WRITE;
            amo_pkg::WRITE:  state_nxt = amo_pkg::DONE;
            amo_pkg::DONE:   state_nxt = amo_pkg::IDLE;
            default:         state_nxt = amo_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= amo_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // The read strobe and the timer load share the READ cycle
    assign mem_rd     = state == amo_pkg::READ;
    assign timer_load = state == amo_pkg::READ;
    assign mem_we     = state == amo_pkg::WRITE;
    assign done       = state == amo_pkg::DONE;

    // Memory data is valid in the last WAIT cycle, ALU output in MODIFY
    always_ff @(posedge clk) begin
        if ((state == amo_pkg::WAIT) && expired) begin
            old_data <= mem_rdata;
        end
        if (state == amo_pkg::MODIFY) begin
            new_data <= alu_result;
        end
    end

    // A write-back always belongs to the read issued one latency plus two states earlier
    rmw_order_chk: assert property (@(posedge clk) disable iff (!arst_n)
        mem_we |-> $past(mem_rd, `AMO_MEM_RD_LAT + 2));

    // The register block must wait for done before launching again
    start_idle_chk: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> state == amo_pkg::IDLE);

    // The timer holds the FSM in WAIT for exactly the memory read latency
    wait_len_chk: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rd |=> (state == amo_pkg::WAIT)[*`AMO_MEM_RD_LAT]
                   ##1 (state == amo_pkg::MODIFY));

endmodule

`default_nettype wire

//--- source/amo_apb_regs.sv
// AMO APB register block
// Holds address, operand, command, result and status registers, decodes the
// memory window and launches engine commands, stalling the APB until done
`timescale 1ns/1ps
`default_nettype none

`include "amo_macros.svh"

module amo_apb_regs (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [`AMO_PADDR_W-1:0]  paddr,
    input  logic [`AMO_DATA_W-1:0]   pwdata,
    output logic [`AMO_DATA_W-1:0]   prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     start,
    output amo_pkg::amo_op_t         cmd_op,
    output logic [`AMO_ADDR_W-1:0]   cmd_addr,
    output logic [`AMO_DATA_W-1:0]   cmd_operand,
    output logic                     cmd_rd_only,
    input  logic                     done,
    input  logic [`AMO_DATA_W-1:0]   old_data
);

    localparam logic [`AMO_PADDR_W-1:0] win_lo = `AMO_WIN_BASE;
    localparam logic [`AMO_PADDR_W-1:0] win_hi = `AMO_WIN_BASE + 4 * `AMO_WIN_WORDS;

    logic                    access;
    logic                    is_win;
    logic                    is_cmd;
    logic                    op_legal;
    logic                    launch_req;
    logic                    launch;
    logic                    complete;
    logic                    pending;
    logic                    err;
    logic                    cmd_win;
    logic [`AMO_ADDR_W-1:0]  addr_q;
    logic [`AMO_DATA_W-1:0]  operand_q;
    logic [`AMO_DATA_W-1:0]  result_q;
    amo_pkg::amo_op_t        last_op;
    logic [`AMO_DATA_W-1:0]  rd_mux;

    function automatic logic legal_code(input logic [4:0] code);
        logic ok;
        case (amo_pkg::amo_op_t'(code))
            amo_pkg::AMO_SWAP, amo_pkg::AMO_ADD, amo_pkg::AMO_XOR,
            amo_pkg::AMO_AND, amo_pkg::AMO_OR, amo_pkg::AMO_MIN,
            amo_pkg::AMO_MAX, amo_pkg::AMO_MINU, amo_pkg::AMO_MAXU: ok = 1'b1;
            default: ok = 1'b0;
        endcase
        return ok;
    endfunction

    assign access   = psel & penable;
    assign is_win   = (paddr >= win_lo) && (paddr < win_hi);
    assign is_cmd   = paddr == `AMO_REG_CMD;
    assign op_legal = legal_code(pwdata[4:0]);

    // Window reads, window writes and legal CMD writes go through the engine
    assign launch_req = is_win | (pwrite & is_cmd & op_legal);
    assign launch     = access & launch_req & ~pending;

    // Engine accesses hold the bus until done, everything else finishes at once
    assign pready   = access & (launch_req ? (pending & done) : 1'b1);
    assign pslverr  = access & pwrite & is_cmd & ~op_legal;
    assign complete = access & pready;

    always_comb begin
        if (is_win) begin
            rd_mux = old_data;
        end else begin
            case (paddr)
                `AMO_REG_ADDR:    rd_mux = `AMO_DATA_W'(addr_q);
                `AMO_REG_OPERAND: rd_mux = operand_q;
                `AMO_REG_CMD:     rd_mux = `AMO_DATA_W'(last_op);
                `AMO_REG_RESULT:  rd_mux = result_q;
                `AMO_REG_STATUS:  rd_mux = {{(`AMO_DATA_W-2){1'b0}}, err, pending};
                default:          rd_mux = '0;
            endcase
        end
    end

    // Read data only shows up in the cycle the transfer completes
    assign prdata = (complete & ~pwrite) ? rd_mux : '0;

    // Command handshake and error flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
            start   <= 1'b0;
            err     <= 1'b0;
        end else begin
            start <= launch;
            if (launch) begin
                pending <= 1'b1;
            end else if (done) begin
                pending <= 1'b0;
            end
            // A legal CMD write clears the error, an illegal one sets it
            if (launch & ~is_win) begin
                err <= 1'b0;
            end else if (complete & pslverr) begin
                err <= 1'b1;
            end
        end
    end

    // Programmed registers
    always_ff @(posedge clk) begin
        if (complete & pwrite & (paddr == `AMO_REG_ADDR)) begin
            addr_q <= pwdata[`AMO_ADDR_W-1:0];
        end
        if (complete & pwrite & (paddr == `AMO_REG_OPERAND)) begin
            operand_q <= pwdata;
        end
        // Window traffic must not disturb the RESULT of the last CMD operation
        if (done & pending & ~cmd_win) begin
            result_q <= old_data;
        end
    end

    // Command fields stay stable from start until done
    always_ff @(posedge clk) begin
        if (launch) begin
            cmd_win <= is_win;
            if (is_win) begin
                cmd_addr    <= paddr[`AMO_ADDR_W+1:2];
                cmd_operand <= pwdata;
                cmd_op      <= amo_pkg::AMO_SWAP;
                cmd_rd_only <= ~pwrite;
            end else begin
                cmd_addr    <= addr_q;
                cmd_operand <= operand_q;
                cmd_op      <= amo_pkg::amo_op_t'(pwdata[4:0]);
                cmd_rd_only <= 1'b0;
                last_op     <= amo_pkg::amo_op_t'(pwdata[4:0]);
            end
        end
    end

    penable_psel_chk: assert property (@(posedge clk) disable iff (!arst_n)
        penable |-> psel);

    // Only one command may be outstanding between start and done
    single_cmd_chk: assert property (@(posedge clk) disable iff (!arst_n)
        start |=> (!start until done));

endmodule

`default_nettype wire

//--- source/amo_subsys.sv
// AMO subsystem top
// APB register block driving a single-item read-modify-write engine
// over a 16-word scratch memory
`timescale 1ns/1ps
`default_nettype none

`include "amo_macros.svh"

module amo_subsys (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [`AMO_PADDR_W-1:0]  paddr,
    input  logic [`AMO_DATA_W-1:0]   pwdata,
    output logic [`AMO_DATA_W-1:0]   prdata,
    output logic                     pready,
    output logic                     pslverr
);

    // Command from the register block, held until done
    logic                    start;
    amo_pkg::amo_op_t        cmd_op;
    logic [`AMO_ADDR_W-1:0]  cmd_addr;
    logic [`AMO_DATA_W-1:0]  cmd_operand;
    logic                    cmd_rd_only;
    logic                    done;

    // Engine internals
    logic                    timer_load;
    logic                    expired;
    logic                    mem_rd;
    logic                    mem_we;
    logic [`AMO_DATA_W-1:0]  mem_rdata;
    logic [`AMO_DATA_W-1:0]  alu_result;
    logic [`AMO_DATA_W-1:0]  old_data;
    logic [`AMO_DATA_W-1:0]  new_data;

    amo_apb_regs i_amo_apb_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .start       (start),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_operand (cmd_operand),
        .cmd_rd_only (cmd_rd_only),
        .done        (done),
        .old_data    (old_data)
    );

    amo_ctrl_fsm i_amo_ctrl_fsm (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .cmd_rd_only (cmd_rd_only),
        .done        (done),
        .timer_load  (timer_load),
        .expired     (expired),
        .mem_rd      (mem_rd),
        .mem_we      (mem_we),
        .mem_rdata   (mem_rdata),
        .alu_result  (alu_result),
        .old_data    (old_data),
        .new_data    (new_data)
    );

    amo_wait_timer i_amo_wait_timer (
        .clk        (clk),
        .arst_n     (arst_n),
        .timer_load (timer_load),
        .expired    (expired)
    );

    // Address comes straight from the held command, data from the ALU stage
    amo_scratch_mem i_amo_scratch_mem (
        .clk       (clk),
        .mem_rd    (mem_rd),
        .mem_we    (mem_we),
        .mem_addr  (cmd_addr),
        .mem_wdata (new_data),
        .mem_rdata (mem_rdata)
    );

    amo_alu i_amo_alu (
        .op       (cmd_op),
        .rs1_load (old_data),
        .rs2      (cmd_operand),
        .result   (alu_result)
    );

endmodule

`default_nettype wire

//--- tb/amo_tb.sv
// AMO subsystem testbench
// Directed APB tests of the window, every AMO operation, illegal codes and status,
// checked against a word-level memory model and a reference AMO function
`timescale 1ns/1ps
`default_nettype none

`include "amo_macros.svh"

module amo_tb;

    // One run_amo costs seven APB accesses, the min and max pairs add a window write
    localparam int amo_accesses    = 7;
    localparam int num_accesses    = 3 * `AMO_WIN_WORDS + 5 * 4 * amo_accesses
                                     + 4 * 4 * (amo_accesses + 1) + 2 * (7 + amo_accesses);
    localparam int watchdog_cycles = num_accesses * (`AMO_MEM_RD_LAT + 8) + 100;
    localparam int pready_bound    = `AMO_MEM_RD_LAT + 20;

    localparam logic [`AMO_PADDR_W-1:0] reg_addr    = `AMO_REG_ADDR;
    localparam logic [`AMO_PADDR_W-1:0] reg_operand = `AMO_REG_OPERAND;
    localparam logic [`AMO_PADDR_W-1:0] reg_cmd     = `AMO_REG_CMD;
    localparam logic [`AMO_PADDR_W-1:0] reg_result  = `AMO_REG_RESULT;
    localparam logic [`AMO_PADDR_W-1:0] reg_status  = `AMO_REG_STATUS;

    logic                    clk;
    logic                    arst_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`AMO_PADDR_W-1:0] paddr;
    logic [`AMO_DATA_W-1:0]  pwdata;
    logic [`AMO_DATA_W-1:0]  prdata;
    logic                    pready;
    logic                    pslverr;

    // Expected memory contents and the register state of the last legal command
    logic [`AMO_DATA_W-1:0]  model_mem [`AMO_WIN_WORDS];
    logic [`AMO_DATA_W-1:0]  last_result;
    amo_pkg::amo_op_t        last_op;
    logic [31:0]             lcg_state;

    amo_subsys i_amo_subsys (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [`AMO_DATA_W-1:0] got,
                              input logic [`AMO_DATA_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s: got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_op(input string name, input amo_pkg::amo_op_t got,
                            input amo_pkg::amo_op_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s: got 0x%02h expected 0x%02h", name, got, exp));
        end
    endtask

    // Numerical Recipes constants, the upper half carries the better bits
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]} ^ lcg_state;
    endfunction

    // Expected new memory value of an AMO, following the RISC-V definitions
    function automatic logic [`AMO_DATA_W-1:0] amo_expect(input amo_pkg::amo_op_t op,
            input logic [`AMO_DATA_W-1:0] old_val, input logic [`AMO_DATA_W-1:0] opd);
        logic [`AMO_DATA_W-1:0] res;
        case (op)
            amo_pkg::AMO_SWAP: res = opd;
            amo_pkg::AMO_ADD:  res = old_val + opd;
            amo_pkg::AMO_XOR:  res = old_val ^ opd;
            amo_pkg::AMO_AND:  res = old_val & opd;
            amo_pkg::AMO_OR:   res = old_val | opd;
            amo_pkg::AMO_MIN:  res = ($signed(old_val) < $signed(opd)) ? old_val : opd;
            amo_pkg::AMO_MAX:  res = ($signed(old_val) > $signed(opd)) ? old_val : opd;
            amo_pkg::AMO_MINU: res = (old_val < opd) ? old_val : opd;
            amo_pkg::AMO_MAXU: res = (old_val > opd) ? old_val : opd;
            default:           res = old_val;
        endcase
        return res;
    endfunction

    function automatic logic [`AMO_PADDR_W-1:0] win_addr(input int idx);
        return `AMO_PADDR_W'(`AMO_WIN_BASE + 4 * idx);
    endfunction

    // Setup on one falling edge, access on the next, sampled mid low phase
    task automatic apb_xfer(input logic wr, input logic [`AMO_PADDR_W-1:0] addr,
                            input logic [`AMO_DATA_W-1:0] wdata,
                            output logic [`AMO_DATA_W-1:0] rdata, output logic slverr);
        int waited;
        waited = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready && waited < pready_bound) begin
            waited++;
            @(negedge clk);
            #1;
        end
        if (!pready) begin
            abort_run($sformatf("APB access to 0x%03h never saw pready", addr));
        end
        rdata  = prdata;
        slverr = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_write(input logic [`AMO_PADDR_W-1:0] addr,
                             input logic [`AMO_DATA_W-1:0] data);
        logic [`AMO_DATA_W-1:0] unused;
        logic                   slverr;
        apb_xfer(1'b1, addr, data, unused, slverr);
        check_flag("pslverr", slverr, 1'b0);
    endtask

    task automatic reg_read(input logic [`AMO_PADDR_W-1:0] addr,
                            output logic [`AMO_DATA_W-1:0] data);
        logic slverr;
        apb_xfer(1'b0, addr, '0, data, slverr);
        check_flag("pslverr", slverr, 1'b0);
    endtask

    // Status is clean and CMD, RESULT and the word all match the model
    task automatic check_after_cmd(input int idx, input logic exp_err);
        logic [`AMO_DATA_W-1:0] rd;
        reg_read(reg_result, rd);
        check_data("result", rd, last_result);
        reg_read(reg_status, rd);
        check_flag("status_busy", rd[0], 1'b0);
        check_flag("status_err", rd[1], exp_err);
        reg_read(reg_cmd, rd);
        check_op("cmd_op", amo_pkg::amo_op_t'(rd[4:0]), last_op);
        reg_read(win_addr(idx), rd);
        check_data($sformatf("mem[%0d]", idx), rd, model_mem[idx]);
    endtask

    task automatic run_amo(input amo_pkg::amo_op_t op, input int idx,
                           input logic [`AMO_DATA_W-1:0] opd);
        reg_write(reg_addr, `AMO_DATA_W'(idx));
        reg_write(reg_operand, opd);
        reg_write(reg_cmd, `AMO_DATA_W'(op));
        last_result    = model_mem[idx];
        last_op        = op;
        model_mem[idx] = amo_expect(op, model_mem[idx], opd);
        check_after_cmd(idx, 1'b0);
    endtask

    task automatic test_window_round_trip();
        logic [`AMO_DATA_W-1:0] rd;
        for (int i = 0; i < `AMO_WIN_WORDS; i++) begin
            model_mem[i] = lcg_next();
            reg_write(win_addr(i), model_mem[i]);
        end
        // The second pass shows that a window read leaves the word alone
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < `AMO_WIN_WORDS; i++) begin
                reg_read(win_addr(i), rd);
                check_data($sformatf("mem[%0d]", i), rd, model_mem[i]);
            end
        end
    endtask

    task automatic test_logic_ops();
        amo_pkg::amo_op_t ops [5];
        ops = '{amo_pkg::AMO_SWAP, amo_pkg::AMO_ADD, amo_pkg::AMO_XOR,
                amo_pkg::AMO_AND, amo_pkg::AMO_OR};
        for (int k = 0; k < 5; k++) begin
            for (int n = 0; n < 4; n++) begin
                run_amo(ops[k], int'(lcg_next() % `AMO_WIN_WORDS), lcg_next());
            end
        end
    endtask

    task automatic test_min_max();
        amo_pkg::amo_op_t       ops [4];
        logic [`AMO_DATA_W-1:0] old_vals [4];
        logic [`AMO_DATA_W-1:0] opds [4];
        int                     idx;
        ops = '{amo_pkg::AMO_MIN, amo_pkg::AMO_MAX, amo_pkg::AMO_MINU, amo_pkg::AMO_MAXU};
        for (int k = 0; k < 4; k++) begin
            // Mixed signs in both orders, an equal pair and a random mixed pair
            old_vals[0] = 32'h7FFF_0000;
            opds[0]     = 32'h8000_1234;
            old_vals[1] = 32'h8000_0001;
            opds[1]     = 32'h0000_0005;
            old_vals[2] = 32'hC0DE_0001;
            opds[2]     = 32'hC0DE_0001;
            old_vals[3] = lcg_next() | 32'h8000_0000;
            opds[3]     = lcg_next() & 32'h7FFF_FFFF;
            for (int p = 0; p < 4; p++) begin
                idx = (4 * k + p) % `AMO_WIN_WORDS;
                model_mem[idx] = old_vals[p];
                reg_write(win_addr(idx), old_vals[p]);
                run_amo(ops[k], idx, opds[p]);
            end
        end
    endtask

    task automatic test_illegal_op();
        logic [4:0]             codes [2];
        logic [`AMO_DATA_W-1:0] rd;
        logic                   slverr;
        int                     idx;
        codes = '{5'b00010, 5'b11111};
        for (int k = 0; k < 2; k++) begin
            idx = int'(lcg_next() % `AMO_WIN_WORDS);
            reg_write(reg_addr, `AMO_DATA_W'(idx));
            reg_write(reg_operand, lcg_next());
            apb_xfer(1'b1, reg_cmd, `AMO_DATA_W'(codes[k]), rd, slverr);
            check_flag("pslverr", slverr, 1'b1);
            // Memory, RESULT and CMD keep what the last legal command left
            check_after_cmd(idx, 1'b1);
            run_amo(amo_pkg::AMO_ADD, idx, lcg_next());
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("Timeout: run did not finish within %0d cycles",
                            watchdog_cycles));
    end

    initial begin
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        lcg_state = 32'd67;
        for (int i = 0; i < `AMO_WIN_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_flag("pready", pready, 1'b0);
        check_flag("pslverr", pslverr, 1'b0);
        test_window_round_trip();
        test_logic_ops();
        test_min_max();
        test_illegal_op();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/amo_pkg.sv
source/amo_alu.sv
source/amo_wait_timer.sv
source/amo_scratch_mem.sv
source/amo_ctrl_fsm.sv
source/amo_apb_regs.sv
source/amo_subsys.sv
tb/amo_tb.sv

//--- Bender.yml
package:
  name: amo_subsys

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/amo_pkg.sv
      - source/amo_alu.sv
      - source/amo_wait_timer.sv
      - source/amo_scratch_mem.sv
      - source/amo_ctrl_fsm.sv
      - source/amo_apb_regs.sv
      - source/amo_subsys.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/amo_tb.sv
